//--- hw/cache_pkg.sv
package cache_pkg;

        localparam int num_ways  = 2;
        localparam int num_banks = 4;
        localparam int index_w   = 8;
        localparam int tag_w     = 20;
        localparam int offset_w  = 4;
        localparam int num_sets  = 1 << index_w;

        typedef logic [31:0] word_t;

        // bank 3 in the top word, bank 0 at the bottom
        typedef logic [num_banks*32-1:0] line_t;

        typedef struct packed {
                logic [tag_w-1:0]    tag;
                logic [index_w-1:0]  index;
                logic [offset_w-1:0] offset;   // [3:2] picks the bank
        } addr_fields_t;

        typedef union packed {
                logic [31:0]  raw;
                addr_fields_t f;
        } cache_addr_u;

        typedef struct packed {
                logic        wr;       // 1 write, 0 read
                cache_addr_u addr;
                logic [3:0]  wstrb;
                word_t       wdata;
        } cpu_req_t;

        typedef enum logic [4:0] {
                idle    = 5'b00001,
                lookup  = 5'b00010,
                miss    = 5'b00100,
                replace = 5'b01000,
                refill  = 5'b10000
        } state_e;

endpackage

//--- hw/cache_ctrl.sv
module cache_ctrl (
        input  logic                          clk,
        input  logic                          resetn,
        input  logic                          valid,
        input  cache_pkg::cpu_req_t           req,
        output logic                          addr_ok,
        output logic                          data_ok,
        output logic                          rd_req,
        output logic [31:0]                   rd_addr,
        input  logic                          rd_rdy,
        input  logic                          ret_valid,
        input  logic                          ret_last,
        output logic                          wr_req,
        output logic [31:0]                   wr_addr,
        input  logic                          wr_rdy,
        input  logic                          hit,
        input  logic                          victim_dirty,
        input  logic [cache_pkg::tag_w-1:0]   victim_tag,
        output logic [cache_pkg::index_w-1:0] lookup_index,
        output cache_pkg::cpu_req_t           cur_req,
        output logic                          hit_write,
        output logic                          refill_we,
        output logic [1:0]                    refill_beat,
        output logic                          refill_done
);

        cache_pkg::state_e state;
        cache_pkg::state_e state_nxt;
        logic              accept;
        logic [1:0]        req_bank;

        assign addr_ok  = state == cache_pkg::idle;
        assign accept   = valid && addr_ok;
        assign req_bank = cur_req.addr.f.offset[3:2];

        // new index while idle, held index otherwise so the rams keep the line
        assign lookup_index = addr_ok ? req.addr.f.index : cur_req.addr.f.index;

        always_ff @(posedge clk) begin
                if (!resetn)
                        state <= cache_pkg::idle;
                else
                        state <= state_nxt;
        end

        always_comb begin
                state_nxt = state;
                case (state)
                        cache_pkg::idle: begin
                                if (accept)
                                        state_nxt = cache_pkg::lookup;
                        end
                        cache_pkg::lookup: begin
                                state_nxt = hit ? cache_pkg::idle : cache_pkg::miss;
                        end
                        cache_pkg::miss: begin
                                // clean victim skips the write-back
                                if (!victim_dirty || wr_rdy)
                                        state_nxt = cache_pkg::replace;
                        end
                        cache_pkg::replace: begin
                                if (rd_rdy)
                                        state_nxt = cache_pkg::refill;
                        end
                        cache_pkg::refill: begin
                                if (ret_valid && ret_last)
                                        state_nxt = cache_pkg::idle;
                        end
                        default: state_nxt = cache_pkg::idle;
                endcase
        end

        always_ff @(posedge clk) begin
                if (accept)
                        cur_req <= req;
        end

        assign refill_we   = (state == cache_pkg::refill) && ret_valid;
        assign refill_done = refill_we && ret_last;

        always_ff @(posedge clk) begin
                if (!resetn)
                        refill_beat <= 2'd0;
                else if (refill_we)
                        refill_beat <= ret_last ? 2'd0 : refill_beat + 2'd1;
        end

        assign hit_write = (state == cache_pkg::lookup) && hit && cur_req.wr;

        // writes ack in lookup, read misses on their own beat
        assign data_ok = (state == cache_pkg::lookup) && (hit || cur_req.wr) ||
                         refill_we && !cur_req.wr && (refill_beat == req_bank);

        assign rd_req  = state == cache_pkg::replace;
        assign rd_addr = {cur_req.addr.raw[31:cache_pkg::offset_w],
                          {cache_pkg::offset_w{1'b0}}};

        assign wr_req  = (state == cache_pkg::miss) && victim_dirty;
        assign wr_addr = {victim_tag, cur_req.addr.f.index, {cache_pkg::offset_w{1'b0}}};

endmodule

//--- hw/tag_store.sv
module tag_store (
        input  logic                           clk,
        input  logic                           resetn,
        input  logic [cache_pkg::index_w-1:0]  lookup_index,
        input  cache_pkg::cpu_req_t            cur_req,
        input  logic                           hit_write,
        input  logic                           refill_done,
        output logic [cache_pkg::num_ways-1:0] way_hit,
        output logic                           hit,
        output logic                           victim_way,
        output logic                           victim_dirty,
        output logic [cache_pkg::tag_w-1:0]    victim_tag
);

        logic [cache_pkg::tag_w-1:0]    tag_ram [cache_pkg::num_ways][cache_pkg::num_sets];
        logic [cache_pkg::tag_w-1:0]    tag_q [cache_pkg::num_ways];
        logic [cache_pkg::num_sets-1:0] valid_bits [cache_pkg::num_ways];
        logic [cache_pkg::num_sets-1:0] dirty_bits [cache_pkg::num_ways];
        logic [cache_pkg::index_w-1:0]  idx;
        logic [cache_pkg::tag_w-1:0]    tag;

        assign idx = cur_req.addr.f.index;
        assign tag = cur_req.addr.f.tag;

        always_ff @(posedge clk) begin
                for (int w = 0; w < cache_pkg::num_ways; w++) begin
                        if (refill_done && victim_way == 1'(w))
                                tag_ram[w][idx] <= tag;
                        tag_q[w] <= tag_ram[w][lookup_index];   // sync read
                end
        end

        always_ff @(posedge clk) begin
                if (!resetn) begin
                        for (int w = 0; w < cache_pkg::num_ways; w++) begin
                                valid_bits[w] <= '0;
                                dirty_bits[w] <= '0;
                        end
                end else if (refill_done) begin
                        valid_bits[victim_way][idx] <= 1'b1;
                        dirty_bits[victim_way][idx] <= cur_req.wr;   // merged write miss
                end else if (hit_write) begin
                        dirty_bits[way_hit[1]][idx] <= 1'b1;
                end
        end

        // round robin, flips once per refill
        always_ff @(posedge clk) begin
                if (!resetn)
                        victim_way <= 1'b0;
                else if (refill_done)
                        victim_way <= ~victim_way;
        end

        always_comb begin
                for (int w = 0; w < cache_pkg::num_ways; w++)
                        way_hit[w] = valid_bits[w][idx] && (tag_q[w] == tag);
        end

        assign hit          = |way_hit;
        assign victim_tag   = tag_q[victim_way];
        assign victim_dirty = valid_bits[victim_way][idx] && dirty_bits[victim_way][idx];

endmodule

//--- hw/data_store.sv
module data_store (
        input  logic                           clk,
        input  logic [cache_pkg::index_w-1:0]  lookup_index,
        input  cache_pkg::cpu_req_t            cur_req,
        input  logic [cache_pkg::num_ways-1:0] way_hit,
        input  logic                           victim_way,
        input  logic                           hit_write,
        input  logic                           refill_we,
        input  logic [1:0]                     refill_beat,
        input  cache_pkg::word_t               ret_data,
        output cache_pkg::word_t               rdata,
        output cache_pkg::line_t               victim_line
);

        cache_pkg::word_t bank_ram [cache_pkg::num_ways][cache_pkg::num_banks][cache_pkg::num_sets];
        cache_pkg::word_t bank_q [cache_pkg::num_ways][cache_pkg::num_banks];
        logic [3:0]       bank_we [cache_pkg::num_ways][cache_pkg::num_banks];
        cache_pkg::word_t merged;
        cache_pkg::word_t wr_word;
        logic [1:0]       req_bank;
        logic [cache_pkg::index_w-1:0] idx;

        assign req_bank = cur_req.addr.f.offset[3:2];
        assign idx      = cur_req.addr.f.index;

        // memory word with the pending store bytes laid over it
        always_comb begin
                for (int k = 0; k < 4; k++)
                        merged[8*k +: 8] = cur_req.wstrb[k] ? cur_req.wdata[8*k +: 8]
                                                            : ret_data[8*k +: 8];
        end

        assign wr_word = !refill_we ? cur_req.wdata :
                         (cur_req.wr && refill_beat == req_bank) ? merged : ret_data;

        always_comb begin
                for (int w = 0; w < cache_pkg::num_ways; w++) begin
                        for (int b = 0; b < cache_pkg::num_banks; b++) begin
                                bank_we[w][b] = 4'h0;
                                if (hit_write && way_hit[w] && req_bank == 2'(b))
                                        bank_we[w][b] = cur_req.wstrb;
                                if (refill_we && victim_way == 1'(w) && refill_beat == 2'(b))
                                        bank_we[w][b] = 4'hf;   // whole beat
                        end
                end
        end

        always_ff @(posedge clk) begin
                for (int w = 0; w < cache_pkg::num_ways; w++) begin
                        for (int b = 0; b < cache_pkg::num_banks; b++) begin
                                for (int k = 0; k < 4; k++) begin
                                        if (bank_we[w][b][k])
                                                bank_ram[w][b][idx][8*k +: 8] <= wr_word[8*k +: 8];
                                end
                                bank_q[w][b] <= bank_ram[w][b][lookup_index];
                        end
                end
        end

        // refill data bypasses the banks
        assign rdata = refill_we ? ret_data :
                       way_hit[1] ? bank_q[1][req_bank] : bank_q[0][req_bank];

        assign victim_line = {bank_q[victim_way][3], bank_q[victim_way][2],
                              bank_q[victim_way][1], bank_q[victim_way][0]};

endmodule

//--- hw/cache_top.sv
module cache_top (
        input  logic                clk,
        input  logic                resetn,
        // cpu side
        input  logic                valid,
        input  cache_pkg::cpu_req_t req,
        output logic                addr_ok,
        output logic                data_ok,
        output cache_pkg::word_t    rdata,
        // bridge side
        output logic                rd_req,
        output logic [31:0]         rd_addr,
        input  logic                rd_rdy,
        input  logic                ret_valid,
        input  logic                ret_last,
        input  cache_pkg::word_t    ret_data,
        output logic                wr_req,
        output logic [31:0]         wr_addr,
        output cache_pkg::line_t    wr_data,
        input  logic                wr_rdy
);

        logic [cache_pkg::num_ways-1:0] way_hit;
        logic                           hit;
        logic                           victim_way;
        logic                           victim_dirty;
        logic [cache_pkg::tag_w-1:0]    victim_tag;
        logic [cache_pkg::index_w-1:0]  lookup_index;
        cache_pkg::cpu_req_t            cur_req;
        logic                           hit_write;
        logic                           refill_we;
        logic [1:0]                     refill_beat;
        logic                           refill_done;

        cache_ctrl u_ctrl (
                .clk          (clk),
                .resetn       (resetn),
                .valid        (valid),
                .req          (req),
                .addr_ok      (addr_ok),
                .data_ok      (data_ok),
                .rd_req       (rd_req),
                .rd_addr      (rd_addr),
                .rd_rdy       (rd_rdy),
                .ret_valid    (ret_valid),
                .ret_last     (ret_last),
                .wr_req       (wr_req),
                .wr_addr      (wr_addr),
                .wr_rdy       (wr_rdy),
                .hit          (hit),
                .victim_dirty (victim_dirty),
                .victim_tag   (victim_tag),
                .lookup_index (lookup_index),
                .cur_req      (cur_req),
                .hit_write    (hit_write),
                .refill_we    (refill_we),
                .refill_beat  (refill_beat),
                .refill_done  (refill_done)
        );

        tag_store u_tags (
                .clk          (clk),
                .resetn       (resetn),
                .lookup_index (lookup_index),
                .cur_req      (cur_req),
                .hit_write    (hit_write),
                .refill_done  (refill_done),
                .way_hit      (way_hit),
                .hit          (hit),
                .victim_way   (victim_way),
                .victim_dirty (victim_dirty),
                .victim_tag   (victim_tag)
        );

        data_store u_data (
                .clk          (clk),
                .lookup_index (lookup_index),
                .cur_req      (cur_req),
                .way_hit      (way_hit),
                .victim_way   (victim_way),
                .hit_write    (hit_write),
                .refill_we    (refill_we),
                .refill_beat  (refill_beat),
                .ret_data     (ret_data),
                .rdata        (rdata),
                .victim_line  (wr_data)
        );

endmodule

//--- sim/cache_assertions.sv
module cache_assertions (
        input logic              clk,
        input logic              resetn,
        input cache_pkg::state_e state,
        input logic              data_ok,
        input logic              rd_req,
        input logic              rd_rdy,
        input logic [31:0]       rd_addr,
        input logic              wr_req,
        input logic              wr_rdy,
        input logic [31:0]       wr_addr
);

        // one bridge channel at a time
        bridge_exclusive: assert property (@(posedge clk) disable iff (!resetn)
                !(rd_req && wr_req))
                else $error("rd_req and wr_req high in the same cycle");

        rd_held: assert property (@(posedge clk) disable iff (!resetn)
                rd_req && !rd_rdy |=> rd_req && $stable(rd_addr))
                else $error("rd_req dropped or rd_addr changed before rd_rdy");

        wr_held: assert property (@(posedge clk) disable iff (!resetn)
                wr_req && !wr_rdy |=> wr_req && $stable(wr_addr))
                else $error("wr_req dropped or wr_addr changed before wr_rdy");

        no_ack_idle: assert property (@(posedge clk) disable iff (!resetn)
                state == cache_pkg::idle |-> !data_ok)
                else $error("data_ok high while the controller is idle");

endmodule

//--- sim/cache_tb.sv
module cache_tb;

        localparam int num_tests = 6;
        localparam int mem_words = 1 << 14;     // 64 KB bridge memory

        logic                clk;
        logic                resetn;
        logic                valid;
        cache_pkg::cpu_req_t req;
        logic                addr_ok;
        logic                data_ok;
        cache_pkg::word_t    rdata;
        logic                rd_req;
        logic [31:0]         rd_addr;
        logic                rd_rdy;
        logic                ret_valid;
        logic                ret_last;
        cache_pkg::word_t    ret_data;
        logic                wr_req;
        logic [31:0]         wr_addr;
        cache_pkg::line_t    wr_data;
        logic                wr_rdy;

        cache_pkg::word_t    mem [mem_words];       // bridge side
        cache_pkg::word_t    ref_mem [mem_words];   // expected cpu view
        int                  rd_count;
        int                  wr_count;
        logic [31:0]         last_rd_addr;
        logic [31:0]         last_wr_addr;
        cache_pkg::line_t    last_wr_data;

        cache_top UUT (.*);

        bind cache_ctrl cache_assertions u_assertions (
                .clk     (clk),
                .resetn  (resetn),
                .state   (state),
                .data_ok (data_ok),
                .rd_req  (rd_req),
                .rd_rdy  (rd_rdy),
                .rd_addr (rd_addr),
                .wr_req  (wr_req),
                .wr_rdy  (wr_rdy),
                .wr_addr (wr_addr)
        );

        initial begin
                clk = 1'b0;
                forever #50 clk = ~clk;
        end

        function automatic logic [13:0] widx(logic [31:0] a);
                return a[15:2];
        endfunction

        function automatic cache_pkg::word_t merge_bytes(cache_pkg::word_t old_w,
                                                         cache_pkg::word_t new_w,
                                                         logic [3:0] strb);
                cache_pkg::word_t mask;
                mask = {{8{strb[3]}}, {8{strb[2]}}, {8{strb[1]}}, {8{strb[0]}}};
                return (old_w & ~mask) | (new_w & mask);
        endfunction

        function automatic cache_pkg::line_t ref_line(logic [31:0] a);
                return {ref_mem[{a[15:4], 2'd3}], ref_mem[{a[15:4], 2'd2}],
                        ref_mem[{a[15:4], 2'd1}], ref_mem[{a[15:4], 2'd0}]};
        endfunction

        task automatic stop_run(string why);
                $display("%s", why);
                $display("tests failed");
                $fatal(1);
        endtask

        task automatic check_word(string test, string what, logic [31:0] exp, logic [31:0] act);
                assert (act == exp) else
                        stop_run($sformatf("ERR %s %s: expected %h, actual %h",
                                           test, what, exp, act));
        endtask

        task automatic check_line(string test, string what, cache_pkg::line_t exp,
                                  cache_pkg::line_t act);
                assert (act == exp) else
                        stop_run($sformatf("ERR %s %s: expected %h, actual %h",
                                           test, what, exp, act));
        endtask

        // word of one request and the cycles past lookup until data_ok
        task automatic cpu_access(input logic wr, input logic [31:0] addr,
                                  input logic [3:0] strb, input cache_pkg::word_t wdata,
                                  output cache_pkg::word_t data, output int lat);
                cache_pkg::cpu_req_t r;
                r.wr       = wr;
                r.addr.raw = addr;
                r.wstrb    = strb;
                r.wdata    = wdata;
                @(posedge clk);
                valid <= 1'b1;
                req   <= r;
                @(negedge clk);
                while (!addr_ok)
                        @(negedge clk);
                @(posedge clk);         // accepted on this edge
                valid <= 1'b0;
                lat = 0;
                @(negedge clk);
                while (!data_ok) begin
                        lat++;
                        @(negedge clk);
                end
                data = rdata;
        endtask

        task automatic read_check(string test, logic [31:0] addr, output int lat);
                cache_pkg::word_t data;
                cpu_access(1'b0, addr, 4'h0, 32'h0, data, lat);
                check_word(test, $sformatf("rdata @%h", addr), ref_mem[widx(addr)], data);
        endtask

        task automatic write_check(string test, logic [31:0] addr, logic [3:0] strb,
                                   cache_pkg::word_t wdata);
                cache_pkg::word_t data;
                int               lat;
                cpu_access(1'b1, addr, strb, wdata, data, lat);
                ref_mem[widx(addr)] = merge_bytes(ref_mem[widx(addr)], wdata, strb);
                check_word(test, "write data_ok latency", 32'd0, 32'(lat));
        endtask

        task automatic test_reset();
                @(negedge clk);
                check_word("reset", "addr_ok", 32'd1, 32'(addr_ok));
                check_word("reset", "data_ok", 32'd0, 32'(data_ok));
                check_word("reset", "rd_req", 32'd0, 32'(rd_req));
                check_word("reset", "wr_req", 32'd0, 32'(wr_req));
        endtask

        task automatic test_read_miss_hit();
                int rd_before;
                int lat;
                rd_before = rd_count;
                read_check("read_miss_hit", 32'h0000_1048, lat);
                check_word("read_miss_hit", "refills", 32'(rd_before + 1), 32'(rd_count));
                check_word("read_miss_hit", "rd_addr", 32'h0000_1040, last_rd_addr);
                read_check("read_miss_hit", 32'h0000_104c, lat);
                check_word("read_miss_hit", "hit latency", 32'd0, 32'(lat));
                check_word("read_miss_hit", "refills", 32'(rd_before + 1), 32'(rd_count));
        endtask

        task automatic test_write_hit();
                int rd_before;
                int lat;
                rd_before = rd_count;
                write_check("write_hit", 32'h0000_1044, 4'b0101, 32'haabb_ccdd);
                read_check("write_hit", 32'h0000_1044, lat);
                check_word("write_hit", "hit latency", 32'd0, 32'(lat));
                check_word("write_hit", "refills", 32'(rd_before), 32'(rd_count));
        endtask

        task automatic test_write_miss();
                int rd_before;
                int wr_before;
                int lat;
                rd_before = rd_count;
                wr_before = wr_count;
                write_check("write_miss", 32'h0000_2084, 4'b1100, 32'h1234_5678);
                for (int b = 0; b < 4; b++) begin
                        read_check("write_miss", 32'h0000_2080 + 32'(4 * b), lat);
                        check_word("write_miss", "hit latency", 32'd0, 32'(lat));
                end
                check_word("write_miss", "refills", 32'(rd_before + 1), 32'(rd_count));
                check_word("write_miss", "rd_addr", 32'h0000_2080, last_rd_addr);
                check_word("write_miss", "write-backs", 32'(wr_before), 32'(wr_count));
        endtask

        // tags 1 to 3 share set 0x30 and only tag 1 goes dirty
        task automatic test_dirty_eviction();
                int rd_before;
                int wr_before;
                int lat;
                rd_before = rd_count;
                wr_before = wr_count;
                write_check("dirty_eviction", 32'h0000_1304, 4'b0011, 32'hdead_beef);
                read_check("dirty_eviction", 32'h0000_2300, lat);
                check_word("dirty_eviction", "write-backs", 32'(wr_before), 32'(wr_count));
                read_check("dirty_eviction", 32'h0000_3308, lat);
                check_word("dirty_eviction", "write-backs", 32'(wr_before + 1), 32'(wr_count));
                check_word("dirty_eviction", "wr_addr", 32'h0000_1300, last_wr_addr);
                check_line("dirty_eviction", "wr_data", ref_line(32'h0000_1300), last_wr_data);
                check_word("dirty_eviction", "refills", 32'(rd_before + 3), 32'(rd_count));
                read_check("dirty_eviction", 32'h0000_230c, lat);   // other way kept
                check_word("dirty_eviction", "hit latency", 32'd0, 32'(lat));
        endtask

        task automatic test_clean_eviction();
                int rd_before;
                int wr_before;
                int lat;
                rd_before = rd_count;
                wr_before = wr_count;
                read_check("clean_eviction", 32'h0000_1304, lat);   // evicts tag 2
                check_word("clean_eviction", "write-backs", 32'(wr_before), 32'(wr_count));
                check_word("clean_eviction", "refills", 32'(rd_before + 1), 32'(rd_count));
                check_word("clean_eviction", "rd_addr", 32'h0000_1300, last_rd_addr);
                read_check("clean_eviction", 32'h0000_3308, lat);
                check_word("clean_eviction", "hit latency", 32'd0, 32'(lat));
        endtask

        // bridge read channel
        initial begin
                logic [31:0] line_addr;
                int          delay;
                rd_rdy    = 1'b0;
                ret_valid = 1'b0;
                ret_last  = 1'b0;
                ret_data  = '0;
                forever begin
                        @(negedge clk);
                        if (rd_req) begin
                                line_addr = rd_addr;
                                delay     = $urandom_range(3, 0);
                                repeat (delay) @(posedge clk);
                                @(posedge clk);
                                rd_rdy <= 1'b1;
                                @(posedge clk);
                                rd_rdy <= 1'b0;
                                rd_count++;
                                last_rd_addr = line_addr;
                                for (int b = 0; b < 4; b++) begin
                                        ret_valid <= 1'b1;
                                        ret_data  <= mem[{line_addr[15:4], 2'(b)}];
                                        ret_last  <= (b == 3);
                                        @(posedge clk);
                                end
                                ret_valid <= 1'b0;
                                ret_last  <= 1'b0;
                        end
                end
        end

        // bridge write channel
        initial begin
                int delay;
                wr_rdy = 1'b0;
                forever begin
                        @(negedge clk);
                        if (wr_req) begin
                                last_wr_addr = wr_addr;
                                last_wr_data = wr_data;
                                delay        = $urandom_range(3, 0);
                                repeat (delay) @(posedge clk);
                                @(posedge clk);
                                wr_rdy <= 1'b1;
                                @(posedge clk);
                                wr_rdy <= 1'b0;
                                wr_count++;
                                for (int b = 0; b < 4; b++)
                                        mem[{last_wr_addr[15:4], 2'(b)}] = last_wr_data[32*b +: 32];
                        end
                end
        end

        initial begin
                repeat (num_tests * 2000) @(posedge clk);
                stop_run("timeout: the cache stopped answering requests");
        end

        initial begin
                resetn   = 1'b0;
                valid    = 1'b0;
                req      = '0;
                rd_count = 0;
                wr_count = 0;
                void'($urandom(32'hc88b));
                for (int i = 0; i < mem_words; i++) begin
                        mem[14'(i)]     = $urandom;
                        ref_mem[14'(i)] = mem[14'(i)];
                end
                repeat (5) @(posedge clk);
                resetn <= 1'b1;
                test_reset();
                test_read_miss_hit();
                test_write_hit();
                test_write_miss();
                test_dirty_eviction();
                test_clean_eviction();
                $display("all tests passed");
                $finish;
        end

endmodule

//--- list.f
hw/cache_pkg.sv
hw/cache_ctrl.sv
hw/tag_store.sv
hw/data_store.sv
hw/cache_top.sv
sim/cache_assertions.sv
sim/cache_tb.sv

//--- run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f list.f --top-module cache_tb -o cache_sim
if [ $? -ne 0 ]; then
        echo "verilator build failed"
        exit 1
fi

./obj_dir/cache_sim > sim.log 2>&1
sim_status=$?
cat sim.log

if grep -q "tests failed" sim.log; then
        echo "simulation reported a failure"
        exit 1
fi

if [ $sim_status -ne 0 ]; then
        echo "simulation exited with status $sim_status"
        exit 1
fi

echo "simulation passed"
exit 0
